// ==== source/ebox_params.svh ====
`ifndef EBOX_PARAMS_SVH
`define EBOX_PARAMS_SVH

// Data path word, one full 36-bit EBUS word
`define EBOX_WORD_W 36

// Control store address, 256 microwords
`define EBOX_CRAM_AW 8

// Magic number field
// Sized so the whole microword fits below the write address on the EBUS
`define EBOX_MAGIC_W 8

// Queue depths
`define EBOX_UQ_DEPTH 4
`define EBOX_RQ_DEPTH 4

`endif

// ==== source/ebox_pkg.sv ====
`include "ebox_params.svh"

package ebox_pkg;

  typedef logic [`EBOX_WORD_W-1:0] ebusWord;
  typedef logic [`EBOX_CRAM_AW-1:0] cramAddr;
  typedef logic [`EBOX_MAGIC_W-1:0] magicNum;

  typedef enum logic [1:0] {dispNext, dispCall, dispReturn, dispHalt} dispCode;

  typedef enum logic [1:0] {arHold, arMagic, arFromArx, arSum} arSrc;

  typedef enum logic [1:0] {arxHold, arxMagic, arxFromAr, arxFromMq} arxSrc;

  // Shift brings AR bit 0 (the MSB) into the low end of MQ
  typedef enum logic [1:0] {mqHold, mqClear, mqShift, mqFromAr} mqOp;

  typedef enum logic [1:0] {condNone, condArClear, condArxClear, condArlClear} condCode;

  // Emits push the register value from before this microword's update
  typedef enum logic [1:0] {specNone, specEmitAr, specEmitArx, specEmitMq} specCode;

  typedef struct packed {
    cramAddr nextAddr;
    dispCode disp;
    arSrc    arSel;
    arxSrc   arxSel;
    mqOp     mq;
    condCode cond;
    specCode spec;
    magicNum magic;
  } microWord;

  typedef struct packed {
    logic     cramWrite;
    logic     start;
    logic     readAr;
    logic     readArx;
    logic     readMq;
    cramAddr  addr;
    microWord word;
  } diagCmd;

  typedef struct packed {
    logic    arLoad;
    arSrc    arSource;
    logic    arClear;
    logic    arlClear;
    logic    arxLoad;
    arxSrc   arxSource;
    logic    arxClear;
    mqOp     mqControl;
    specCode emitSel;
    logic    emitReq;
    magicNum magic;
  } ctlSignals;

  // Console function codes, octal as on the diagnostic bus
  localparam logic [6:0] diagFuncCramWrite = 7'o040;
  localparam logic [6:0] diagFuncStart     = 7'o041;
  localparam logic [6:0] diagFuncReadAr    = 7'o100;
  localparam logic [6:0] diagFuncReadArx   = 7'o101;
  localparam logic [6:0] diagFuncReadMq    = 7'o102;

endpackage

// ==== source/diagDecode.sv ====
`timescale 1ns/1ps
`include "ebox_params.svh"

module diagDecode (
  input  logic              CTL,
  input  logic              reset,
  input  logic              diagStrobe,
  input  logic [6:0]        diagFunc,
  input  ebox_pkg::ebusWord ebusData,
  output ebox_pkg::diagCmd  cmd
);

  ebox_pkg::diagCmd cmdNext;

  // Function code compare, only while strobed
  always_comb begin
    cmdNext = '0;
    if (diagStrobe) begin
      case (diagFunc)
        ebox_pkg::diagFuncCramWrite: begin
          cmdNext.cramWrite = 1'b1;
          cmdNext.addr = ebusData[`EBOX_WORD_W-1 -: `EBOX_CRAM_AW];
          cmdNext.word = ebusData[$bits(ebox_pkg::microWord)-1:0];
        end
        ebox_pkg::diagFuncStart: begin
          cmdNext.start = 1'b1;
          cmdNext.addr = ebusData[`EBOX_CRAM_AW-1:0];
        end
        ebox_pkg::diagFuncReadAr: begin
          cmdNext.readAr = 1'b1;
        end
        ebox_pkg::diagFuncReadArx: begin
          cmdNext.readArx = 1'b1;
        end
        ebox_pkg::diagFuncReadMq: begin
          cmdNext.readMq = 1'b1;
        end
        default: begin
          cmdNext = '0;
        end
      endcase
    end
  end

  // Command acts one cycle after the strobe
  always_ff @(posedge CTL) begin
    if (reset) begin
      cmd <= '0;
    end else begin
      cmd <= cmdNext;
    end
  end

endmodule

// ==== source/cramSequencer.sv ====
`timescale 1ns/1ps
`include "ebox_params.svh"

module cramSequencer (
  input  logic               CTL,
  input  logic               reset,
  input  ebox_pkg::diagCmd   cmd,
  input  logic               queueFull,
  output logic               push,
  output ebox_pkg::microWord word,
  output logic               halted
);

  localparam int CRAM_SIZE = 1 << `EBOX_CRAM_AW;

  ebox_pkg::microWord cram [CRAM_SIZE];
  ebox_pkg::cramAddr  pc;
  ebox_pkg::cramAddr  retAddr;
  ebox_pkg::cramAddr  pcPlus1;

  // One fetch per cycle while running and there is room downstream
  assign push = ~halted & ~queueFull;
  assign word = cram[pc];
  assign pcPlus1 = pc + 1'b1;

  // Console writes into the store
  always_ff @(posedge CTL) begin
    if (cmd.cramWrite) begin
      cram[cmd.addr] <= cmd.word;
    end
  end

  always_ff @(posedge CTL) begin
    if (reset) begin
      pc <= '0;
      retAddr <= '0;
      halted <= 1'b1;
    end else if (cmd.start) begin
      pc <= cmd.addr;
      halted <= 1'b0;
    end else if (push) begin
      case (word.disp)
        ebox_pkg::dispNext: begin
          pc <= word.nextAddr;
        end
        ebox_pkg::dispCall: begin
          // Single level, a second call overwrites the return point
          retAddr <= pcPlus1;
          pc <= word.nextAddr;
        end
        ebox_pkg::dispReturn: begin
          pc <= retAddr;
        end
        ebox_pkg::dispHalt: begin
          // Halt word itself still goes into the queue
          halted <= 1'b1;
        end
        default: begin
          pc <= pc;
        end
      endcase
    end
  end

endmodule

// ==== source/microQueue.sv ====
`timescale 1ns/1ps

module microQueue #(
  parameter type payloadT = logic,
  parameter int  DEPTH    = 4
) (
  input  logic    CTL,
  input  logic    reset,
  input  logic    push,
  input  payloadT pushData,
  input  logic    pop,
  output payloadT popData,
  output logic    empty,
  output logic    full
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payloadT       mem [DEPTH];
  logic [AW-1:0] wrPtr;
  logic [AW-1:0] rdPtr;
  logic [CW-1:0] count;

  // Wraps for any depth, not only powers of two
  function automatic logic [AW-1:0] nextPtr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge CTL) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      // Push and pop together leave the count alone
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CTL) begin
    if (push) begin
      mem[wrPtr] <= pushData;
    end
  end

  assign popData = mem[rdPtr];
  assign empty = count == '0;
  assign full = count == CW'(DEPTH);

endmodule

// ==== source/ctlDecode.sv ====
`timescale 1ns/1ps

module ctlDecode (
  input  ebox_pkg::microWord  word,
  input  logic                valid,
  output ebox_pkg::ctlSignals ctl
);

  logic condArClr;
  logic condArxClr;
  logic condArlClr;
  logic arSelLoad;
  logic arxSelLoad;
  logic mqActive;
  logic specEmit;

  // Condition field decode
  assign condArClr  = valid && word.cond == ebox_pkg::condArClear;
  assign condArxClr = valid && word.cond == ebox_pkg::condArxClear;
  assign condArlClr = valid && word.cond == ebox_pkg::condArlClear;

  // Select fields
  assign arSelLoad  = valid && word.arSel != ebox_pkg::arHold;
  assign arxSelLoad = valid && word.arxSel != ebox_pkg::arxHold;
  assign mqActive   = valid && word.mq != ebox_pkg::mqHold;

  // Special function
  assign specEmit = valid && word.spec != ebox_pkg::specNone;

  always_comb begin
    // AR, a clear condition wins over the source select
    ctl.arClear = condArClr;
    ctl.arlClear = condArlClr;
    ctl.arLoad = condArClr | condArlClr | arSelLoad;
    if (arSelLoad && !condArClr) begin
      ctl.arSource = word.arSel;
    end else begin
      ctl.arSource = ebox_pkg::arHold;
    end

    // ARX
    ctl.arxClear = condArxClr;
    ctl.arxLoad = condArxClr | arxSelLoad;
    if (arxSelLoad && !condArxClr) begin
      ctl.arxSource = word.arxSel;
    end else begin
      ctl.arxSource = ebox_pkg::arxHold;
    end

    // MQ
    if (mqActive) begin
      ctl.mqControl = word.mq;
    end else begin
      ctl.mqControl = ebox_pkg::mqHold;
    end

    // Readback emit
    ctl.emitReq = specEmit;
    if (specEmit) begin
      ctl.emitSel = word.spec;
    end else begin
      ctl.emitSel = ebox_pkg::specNone;
    end

    // Magic only matters with a magic select, still zero when idle
    if (valid) begin
      ctl.magic = word.magic;
    end else begin
      ctl.magic = '0;
    end
  end

endmodule

// ==== source/arDatapath.sv ====
`timescale 1ns/1ps
`include "ebox_params.svh"

module arDatapath (
  input  logic                CTL,
  input  logic                reset,
  input  ebox_pkg::ctlSignals ctl,
  input  logic                uqEmpty,
  input  ebox_pkg::diagCmd    cmd,
  input  logic                rqFull,
  output logic                uqPop,
  output logic                rqPush,
  output ebox_pkg::ebusWord   rqData
);

  ebox_pkg::ebusWord ar;
  ebox_pkg::ebusWord arx;
  ebox_pkg::ebusWord mq;
  ebox_pkg::ebusWord magicExt;
  ebox_pkg::ebusWord sum;
  ebox_pkg::ebusWord arNext;
  ebox_pkg::ebusWord arxNext;
  ebox_pkg::ebusWord mqNext;
  logic              diagRead;
  logic              emitBlocked;

  assign magicExt = ebox_pkg::ebusWord'(ctl.magic);
  // Carry out of bit 0 is dropped
  assign sum = ar + arx;

  // Console read takes the readback slot this cycle
  assign diagRead = cmd.readAr | cmd.readArx | cmd.readMq;
  assign emitBlocked = ctl.emitReq & (rqFull | diagRead);
  assign uqPop = ~uqEmpty & ~emitBlocked;
  assign rqPush = diagRead | (uqPop & ctl.emitReq);

  always_comb begin
    if (cmd.readAr) begin
      rqData = ar;
    end else if (cmd.readArx) begin
      rqData = arx;
    end else if (cmd.readMq) begin
      rqData = mq;
    end else begin
      case (ctl.emitSel)
        ebox_pkg::specEmitArx: rqData = arx;
        ebox_pkg::specEmitMq:  rqData = mq;
        default:               rqData = ar;
      endcase
    end
  end

  always_comb begin
    case (ctl.arSource)
      ebox_pkg::arMagic:   arNext = magicExt;
      ebox_pkg::arFromArx: arNext = arx;
      ebox_pkg::arSum:     arNext = sum;
      default:             arNext = ar;
    endcase
    if (ctl.arClear) begin
      arNext = '0;
    end
    if (ctl.arlClear) begin
      arNext[`EBOX_WORD_W-1:`EBOX_WORD_W/2] = '0;
    end
  end

  always_comb begin
    case (ctl.arxSource)
      ebox_pkg::arxMagic:  arxNext = magicExt;
      ebox_pkg::arxFromAr: arxNext = ar;
      ebox_pkg::arxFromMq: arxNext = mq;
      default:             arxNext = arx;
    endcase
    if (ctl.arxClear) begin
      arxNext = '0;
    end
  end

  always_comb begin
    case (ctl.mqControl)
      ebox_pkg::mqClear:  mqNext = '0;
      ebox_pkg::mqShift:  mqNext = {mq[`EBOX_WORD_W-2:0], ar[`EBOX_WORD_W-1]};
      ebox_pkg::mqFromAr: mqNext = ar;
      default:            mqNext = mq;
    endcase
  end

  // Registers move on the edge that pops their microword
  always_ff @(posedge CTL) begin
    if (reset) begin
      ar <= '0;
      arx <= '0;
      mq <= '0;
    end else if (uqPop) begin
      if (ctl.arLoad) begin
        ar <= arNext;
      end
      if (ctl.arxLoad) begin
        arx <= arxNext;
      end
      mq <= mqNext;
    end
  end

endmodule

// ==== source/ebox.sv ====
`timescale 1ns/1ps
`include "ebox_params.svh"

module ebox (
  input  logic              CTL,
  input  logic              reset,
  input  logic              diagStrobe,
  input  logic [6:0]        diagFunc,
  input  ebox_pkg::ebusWord ebusData,
  input  logic              rdPop,
  output ebox_pkg::ebusWord rdData,
  output logic              rdEmpty,
  output logic              halted
);

  ebox_pkg::diagCmd    cmd;
  ebox_pkg::microWord  fetchWord;
  ebox_pkg::microWord  headWord;
  ebox_pkg::ctlSignals ctl;
  ebox_pkg::ebusWord   rqData;
  logic                fetchPush;
  logic                uqFull;
  logic                uqEmpty;
  logic                uqValid;
  logic                uqPop;
  logic                rqPush;
  logic                rqFull;

  assign uqValid = ~uqEmpty;

  diagDecode diag (
    .CTL(CTL), .reset(reset), .diagStrobe(diagStrobe), .diagFunc(diagFunc),
    .ebusData(ebusData), .cmd(cmd)
  );

  cramSequencer seq (
    .CTL(CTL), .reset(reset), .cmd(cmd), .queueFull(uqFull),
    .push(fetchPush), .word(fetchWord), .halted(halted)
  );

  // Prefetched microwords
  microQueue #(.payloadT(ebox_pkg::microWord), .DEPTH(`EBOX_UQ_DEPTH)) uq (
    .CTL(CTL), .reset(reset), .push(fetchPush), .pushData(fetchWord),
    .pop(uqPop), .popData(headWord), .empty(uqEmpty), .full(uqFull)
  );

  ctlDecode dec (.word(headWord), .valid(uqValid), .ctl(ctl));

  arDatapath dp (
    .CTL(CTL), .reset(reset), .ctl(ctl), .uqEmpty(uqEmpty), .cmd(cmd),
    .rqFull(rqFull), .uqPop(uqPop), .rqPush(rqPush), .rqData(rqData)
  );

  // EBUS readback words
  microQueue #(.payloadT(ebox_pkg::ebusWord), .DEPTH(`EBOX_RQ_DEPTH)) rq (
    .CTL(CTL), .reset(reset), .push(rqPush), .pushData(rqData),
    .pop(rdPop), .popData(rdData), .empty(rdEmpty), .full(rqFull)
  );

endmodule

// ==== tb/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
  output logic CTL,
  output logic reset
);

  // 10 ns period
  initial begin
    CTL = 1'b0;
    forever begin
      #5 CTL = ~CTL;
    end
  end

  // Held for two rising edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge CTL);
    #1;
    reset = 1'b0;
  end

endmodule

// ==== tb/ebox_chk.sv ====
`timescale 1ns/1ps

module ebox_chk #(
  parameter int DEPTH = 4,
  parameter int CW    = 3
) (
  input logic          CTL,
  input logic          reset,
  input logic          push,
  input logic          pop,
  input logic          empty,
  input logic          full,
  input logic [CW-1:0] count
);

  int failCount = 0;

  pushNotFull: assert property (@(posedge CTL) disable iff (reset) !(push && full))
    else begin
      failCount++;
      $error("push while the queue is full");
    end

  popNotEmpty: assert property (@(posedge CTL) disable iff (reset) !(pop && empty))
    else begin
      failCount++;
      $error("pop while the queue is empty");
    end

  countInRange: assert property (@(posedge CTL) disable iff (reset) count <= CW'(DEPTH))
    else begin
      failCount++;
      $error("queue occupancy above its depth");
    end

endmodule

bind microQueue ebox_chk #(.DEPTH(DEPTH), .CW(CW)) chk (
  .CTL(CTL), .reset(reset), .push(push), .pop(pop), .empty(empty), .full(full),
  .count(count)
);

// ==== tb/ebox_tb.sv ====
`timescale 1ns/1ps
`include "ebox_params.svh"

module ebox_tb;

  // Allows about 30 cycles for each of up to 100 microwords
  localparam int MAX_WORDS = 100;
  localparam int MAX_CYCLES = 30 * MAX_WORDS;

  logic              CTL;
  logic              reset;
  logic              diagStrobe;
  logic [6:0]        diagFunc;
  ebox_pkg::ebusWord ebusData;
  logic              rdPop;
  ebox_pkg::ebusWord rdData;
  logic              rdEmpty;
  logic              halted;

  ebox_pkg::microWord modelCram [1 << `EBOX_CRAM_AW];
  ebox_pkg::ebusWord  modelAr;
  ebox_pkg::ebusWord  modelArx;
  ebox_pkg::ebusWord  modelMq;
  ebox_pkg::ebusWord  expectQ [$];
  ebox_pkg::cramAddr  loadAddr;
  string              testName;
  logic               drainOn;
  int                 cycleCount = 0;

  tbClock clkGen (.CTL(CTL), .reset(reset));

  ebox UUT (
    .CTL(CTL), .reset(reset), .diagStrobe(diagStrobe), .diagFunc(diagFunc),
    .ebusData(ebusData), .rdPop(rdPop), .rdData(rdData), .rdEmpty(rdEmpty),
    .halted(halted)
  );

  task automatic stopWithFailure(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic checkWord(input string name, input ebox_pkg::ebusWord expected,
                           input ebox_pkg::ebusWord actual);
    if (actual !== expected) begin
      stopWithFailure($sformatf("mismatch %s: expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic checkHalted(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      stopWithFailure($sformatf("mismatch %s: expected %b actual %b", name, expected, actual));
    end
  endtask

  // Walks the program the way the sequencer would and queues every emit
  function automatic void predictReadback(input ebox_pkg::cramAddr startAddr);
    ebox_pkg::cramAddr  pc;
    ebox_pkg::cramAddr  retAddr;
    ebox_pkg::microWord w;
    ebox_pkg::ebusWord  nextAr;
    ebox_pkg::ebusWord  nextArx;
    ebox_pkg::ebusWord  nextMq;
    ebox_pkg::ebusWord  magic;
    logic               running;
    pc = startAddr;
    retAddr = '0;
    running = 1'b1;
    while (running) begin
      w = modelCram[pc];
      magic = ebox_pkg::ebusWord'(w.magic);
      // Emit sees the values from before this word
      case (w.spec)
        ebox_pkg::specEmitAr:  expectQ.push_back(modelAr);
        ebox_pkg::specEmitArx: expectQ.push_back(modelArx);
        ebox_pkg::specEmitMq:  expectQ.push_back(modelMq);
        default: ;
      endcase
      case (w.arSel)
        ebox_pkg::arMagic:   nextAr = magic;
        ebox_pkg::arFromArx: nextAr = modelArx;
        ebox_pkg::arSum:     nextAr = modelAr + modelArx;
        default:             nextAr = modelAr;
      endcase
      if (w.cond == ebox_pkg::condArClear) begin
        nextAr = '0;
      end
      if (w.cond == ebox_pkg::condArlClear) begin
        nextAr[`EBOX_WORD_W-1:`EBOX_WORD_W/2] = '0;
      end
      case (w.arxSel)
        ebox_pkg::arxMagic:  nextArx = magic;
        ebox_pkg::arxFromAr: nextArx = modelAr;
        ebox_pkg::arxFromMq: nextArx = modelMq;
        default:             nextArx = modelArx;
      endcase
      if (w.cond == ebox_pkg::condArxClear) begin
        nextArx = '0;
      end
      case (w.mq)
        ebox_pkg::mqClear:  nextMq = '0;
        ebox_pkg::mqShift:  nextMq = {modelMq[`EBOX_WORD_W-2:0], modelAr[`EBOX_WORD_W-1]};
        ebox_pkg::mqFromAr: nextMq = modelAr;
        default:            nextMq = modelMq;
      endcase
      modelAr = nextAr;
      modelArx = nextArx;
      modelMq = nextMq;
      case (w.disp)
        ebox_pkg::dispCall: begin
          retAddr = pc + 1'b1;
          pc = w.nextAddr;
        end
        ebox_pkg::dispReturn: pc = retAddr;
        ebox_pkg::dispHalt:   running = 1'b0;
        default:              pc = w.nextAddr;
      endcase
    end
  endfunction

  // Plain step that falls through to the following address
  function automatic ebox_pkg::microWord stepWord(
    input ebox_pkg::arSrc    arSel,
    input ebox_pkg::arxSrc   arxSel,
    input ebox_pkg::mqOp     mq,
    input ebox_pkg::condCode cond,
    input ebox_pkg::specCode spec,
    input ebox_pkg::magicNum magic
  );
    ebox_pkg::microWord w;
    w.nextAddr = loadAddr + 1'b1;
    w.disp = ebox_pkg::dispNext;
    w.arSel = arSel;
    w.arxSel = arxSel;
    w.mq = mq;
    w.cond = cond;
    w.spec = spec;
    w.magic = magic;
    return w;
  endfunction

  task automatic strobeDiag(input logic [6:0] func, input ebox_pkg::ebusWord data);
    @(posedge CTL);
    #1;
    diagStrobe = 1'b1;
    diagFunc = func;
    ebusData = data;
    @(posedge CTL);
    #1;
    diagStrobe = 1'b0;
  endtask

  task automatic appendWord(input ebox_pkg::microWord w);
    modelCram[loadAddr] = w;
    strobeDiag(ebox_pkg::diagFuncCramWrite, {loadAddr, w});
    loadAddr = loadAddr + 1'b1;
  endtask

  task automatic runProgram(input string name, input ebox_pkg::cramAddr startAddr);
    testName = name;
    predictReadback(startAddr);
    strobeDiag(ebox_pkg::diagFuncStart, ebox_pkg::ebusWord'(startAddr));
    do begin
      @(posedge CTL);
      #1;
    end while (halted);
  endtask

  task automatic waitDrained();
    do begin
      @(posedge CTL);
      #1;
    end while (expectQ.size() != 0 || !rdEmpty);
  endtask

  task automatic readRegisters(input string name);
    testName = name;
    expectQ.push_back(modelAr);
    strobeDiag(ebox_pkg::diagFuncReadAr, '0);
    expectQ.push_back(modelArx);
    strobeDiag(ebox_pkg::diagFuncReadArx, '0);
    expectQ.push_back(modelMq);
    strobeDiag(ebox_pkg::diagFuncReadMq, '0);
    waitDrained();
  endtask

  always @(posedge CTL) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= MAX_CYCLES) begin
      stopWithFailure("timeout: the run did not finish within the cycle limit");
    end
  end

  // Pops readback words with random gaps and compares each with the model
  initial begin : compareReadback
    ebox_pkg::ebusWord expected;
    rdPop = 1'b0;
    forever begin
      @(posedge CTL);
      #1;
      rdPop = 1'b0;
      if (drainOn && !rdEmpty && ($urandom % 3) != 0) begin
        if (expectQ.size() == 0) begin
          stopWithFailure("a readback word arrived when none was expected");
        end
        expected = expectQ.pop_front();
        checkWord(testName, expected, rdData);
        rdPop = 1'b1;
      end
    end
  end

  initial begin : mainSequence
    ebox_pkg::microWord w;
    int i;
    diagStrobe = 1'b0;
    diagFunc = '0;
    ebusData = '0;
    modelAr = '0;
    modelArx = '0;
    modelMq = '0;
    drainOn = 1'b1;
    void'($urandom(74175));
    wait (reset == 1'b0);
    @(posedge CTL);
    #1;

    checkHalted("reset", 1'b1, halted);
    if (!rdEmpty) begin
      stopWithFailure("readback queue is not empty after reset");
    end
    readRegisters("reset");

    // Loads, then Fibonacci growth through the adder so the left-half clear bites
    loadAddr = 8'h10;
    appendWord(stepWord(ebox_pkg::arMagic, ebox_pkg::arxHold, ebox_pkg::mqHold,
                        ebox_pkg::condNone, ebox_pkg::specNone, ebox_pkg::magicNum'($urandom)));
    appendWord(stepWord(ebox_pkg::arHold, ebox_pkg::arxMagic, ebox_pkg::mqHold,
                        ebox_pkg::condNone, ebox_pkg::specEmitAr, ebox_pkg::magicNum'($urandom)));
    for (i = 0; i < 40; i++) begin
      appendWord(stepWord(ebox_pkg::arSum, ebox_pkg::arxFromAr, ebox_pkg::mqHold,
                          ebox_pkg::condNone, ebox_pkg::specEmitAr, '0));
    end
    appendWord(stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqHold,
                        ebox_pkg::condArlClear, ebox_pkg::specEmitAr, '0));
    appendWord(stepWord(ebox_pkg::arSum, ebox_pkg::arxHold, ebox_pkg::mqHold,
                        ebox_pkg::condArlClear, ebox_pkg::specEmitAr, '0));
    w = stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqHold,
                 ebox_pkg::condNone, ebox_pkg::specEmitAr, '0);
    w.disp = ebox_pkg::dispHalt;
    appendWord(w);
    runProgram("loads", 8'h10);
    waitDrained();

    // MQ and ARX moves with the clear conditions
    loadAddr = 8'h50;
    appendWord(stepWord(ebox_pkg::arSum, ebox_pkg::arxHold, ebox_pkg::mqHold,
                        ebox_pkg::condNone, ebox_pkg::specEmitArx, '0));
    appendWord(stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqFromAr,
                        ebox_pkg::condNone, ebox_pkg::specEmitAr, '0));
    appendWord(stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqShift,
                        ebox_pkg::condNone, ebox_pkg::specEmitMq, '0));
    appendWord(stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqShift,
                        ebox_pkg::condNone, ebox_pkg::specEmitMq, '0));
    appendWord(stepWord(ebox_pkg::arHold, ebox_pkg::arxFromMq, ebox_pkg::mqHold,
                        ebox_pkg::condNone, ebox_pkg::specEmitMq, '0));
    appendWord(stepWord(ebox_pkg::arFromArx, ebox_pkg::arxHold, ebox_pkg::mqHold,
                        ebox_pkg::condArxClear, ebox_pkg::specEmitArx, '0));
    appendWord(stepWord(ebox_pkg::arHold, ebox_pkg::arxMagic, ebox_pkg::mqHold,
                        ebox_pkg::condArClear, ebox_pkg::specEmitAr, ebox_pkg::magicNum'($urandom)));
    appendWord(stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqClear,
                        ebox_pkg::condNone, ebox_pkg::specEmitArx, '0));
    appendWord(stepWord(ebox_pkg::arMagic, ebox_pkg::arxHold, ebox_pkg::mqShift,
                        ebox_pkg::condNone, ebox_pkg::specEmitMq, ebox_pkg::magicNum'($urandom)));
    w = stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqHold,
                 ebox_pkg::condNone, ebox_pkg::specEmitAr, '0);
    w.disp = ebox_pkg::dispHalt;
    appendWord(w);
    runProgram("mqMoves", 8'h50);
    waitDrained();

    // Main line at 80 calls the subroutine at C0 twice
    loadAddr = 8'h80;
    appendWord(stepWord(ebox_pkg::arMagic, ebox_pkg::arxHold, ebox_pkg::mqHold,
                        ebox_pkg::condNone, ebox_pkg::specNone, ebox_pkg::magicNum'($urandom)));
    w = stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqHold,
                 ebox_pkg::condNone, ebox_pkg::specEmitAr, '0);
    w.disp = ebox_pkg::dispCall;
    w.nextAddr = 8'hC0;
    appendWord(w);
    w = stepWord(ebox_pkg::arSum, ebox_pkg::arxHold, ebox_pkg::mqHold,
                 ebox_pkg::condNone, ebox_pkg::specEmitArx, '0);
    w.disp = ebox_pkg::dispCall;
    w.nextAddr = 8'hC0;
    appendWord(w);
    w = stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqHold,
                 ebox_pkg::condNone, ebox_pkg::specEmitAr, '0);
    w.disp = ebox_pkg::dispHalt;
    appendWord(w);
    loadAddr = 8'hC0;
    appendWord(stepWord(ebox_pkg::arHold, ebox_pkg::arxMagic, ebox_pkg::mqHold,
                        ebox_pkg::condNone, ebox_pkg::specEmitAr, 8'hA5));
    w = stepWord(ebox_pkg::arHold, ebox_pkg::arxHold, ebox_pkg::mqHold,
                 ebox_pkg::condNone, ebox_pkg::specEmitArx, '0);
    w.disp = ebox_pkg::dispReturn;
    appendWord(w);
    runProgram("callReturn", 8'h80);
    waitDrained();
    checkHalted("callReturn", 1'b1, halted);

    // Ten emits against a readback queue nobody pops
    loadAddr = 8'hE0;
    for (i = 0; i < 10; i++) begin
      w = stepWord(ebox_pkg::arMagic, ebox_pkg::arxHold, ebox_pkg::mqHold,
                   ebox_pkg::condNone, ebox_pkg::specEmitAr, ebox_pkg::magicNum'($urandom));
      if (i == 9) begin
        w.disp = ebox_pkg::dispHalt;
      end
      appendWord(w);
    end
    drainOn = 1'b0;
    runProgram("backPressure", 8'hE0);
    repeat (20) @(posedge CTL);
    #1;
    // Both queues hold fewer than ten words, so fetch must be stalled
    checkHalted("backPressure", 1'b0, halted);
    drainOn = 1'b1;
    waitDrained();

    readRegisters("afterHalt");

    if (UUT.uq.chk.failCount + UUT.rq.chk.failCount == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stopWithFailure("a queue assertion failed during the run");
    end
  end

endmodule

// ==== verilog.f ====
+incdir+source
source/ebox_pkg.sv
source/diagDecode.sv
source/cramSequencer.sv
source/microQueue.sv
source/ctlDecode.sv
source/arDatapath.sv
source/ebox.sv
tb/tbClock.sv
tb/ebox_chk.sv
tb/ebox_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the ebox testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module ebox_tb -o ebox_sim
./obj_dir/ebox_sim > sim.log 2>&1 || true
cat sim.log

if grep -qF '** FAIL **' sim.log || ! grep -qF '** PASS **' sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"
